//--- Makefile
TOP := tb_iir

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f iir_biquad.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-Mdir obj_dir -f iir_biquad.f
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -qx "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- iir_biquad.f
verilog/iir_data_pkg.sv
verilog/iir_ctrl_pkg.sv
verilog/iir_credit_fifo.sv
verilog/iir_run_budget.sv
verilog/iir_ctrl_fsm.sv
verilog/iir_datapath.sv
verilog/iir_top.sv
sim/tb_iir_assert.sv
sim/tb_iir.sv

//--- sim/iir_vectors.txt
// per run: sample count, input gap bits, credit return delay; then a1 a2 b0 b1 b2
// then one line per sample: in_word {sample,last} and expected out_word {sample,last}
// impulse response
0006 0000 0001
2000 f000 4000 2000 1000
0080 0004
0000 0004
0000 0002
0000 0000
0000 01fe
0001 01ff
// mixed signs, random input spacing, new coefficients
0008 0002 0001
1000 0000 2000 e000 0000
00fe 0002
0100 01f8
0020 0002
01e0 01fe
00aa 0002
0000 01fe
0080 0000
01ff 01ff
// slow credit return, history cleared at run start
0006 0000 0014
e000 0000 4000 0000 0000
00fe 0006
00fe 0002
0102 01f6
0000 0004
0040 01fe
01c1 01ff
// end of runs
0000 0000 0000

//--- sim/tb_iir.sv
`timescale 1ns/1ps

module tb_iir;
	import iir_data_pkg::*;
	import iir_ctrl_pkg::*;

	localparam int VEC_WORDS = 128;
	localparam int RUN_TIMEOUT = 3000;
	localparam int DRAIN_TIMEOUT = 400;

	logic clk;
	logic reset;
	logic coef_valid;
	coef_word_t coef_word;
	logic coef_credit;
	logic in_valid;
	sample_word_t in_word;
	logic in_credit;
	logic run_valid;
	run_cmd_t run_cmd;
	logic out_valid;
	result_t out_word;
	logic out_credit;
	logic done;

	logic [15:0] vec [VEC_WORDS];
	logic [31:0] lfsr;
	int cycle;
	int errors;
	int tests_run;
	int tests_failed;
	logic timed_out;

	// credits held by the sender and by the filter, kept across runs
	int coef_credits;
	int in_credits;
	int filter_credits;
	int credit_due [$];

	coef_t coef_q [$];
	sample_word_t sample_q [$];
	result_t expect_q [$];
	int gap_bits;
	int gap_left;
	int credit_delay;
	int sent;
	int received;
	int dones;
	int credit_pulses;
	int test_errors;

	iir_top dut0 (
		.clk(clk),
		.reset(reset),
		.coef_valid(coef_valid),
		.coef_word(coef_word),
		.coef_credit(coef_credit),
		.in_valid(in_valid),
		.in_word(in_word),
		.in_credit(in_credit),
		.run_valid(run_valid),
		.run_cmd(run_cmd),
		.out_valid(out_valid),
		.out_word(out_word),
		.out_credit(out_credit),
		.done(done)
	);

	always #50 clk = ~clk;

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output int val);
		val = 0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_step(lfsr);
			val = (val << 1) | int'(lfsr[0]);
		end
	endtask

	// receiver frees its slot a random time later, one credit per cycle
	task automatic schedule_credit();
		int delay;
		int due;
		take_bits(3, delay);
		due = cycle + credit_delay + delay;
		if (credit_due.size() > 0 && due <= credit_due[$])
			due = credit_due[$] + 1;
		credit_due.push_back(due);
	endtask

	task automatic service_cycle(input logic start);
		result_t want;
		@(posedge clk);
		#1;
		cycle++;
		if (coef_credit)
			coef_credits++;
		if (in_credit)
		begin
			in_credits++;
			credit_pulses++;
		end
		if (done)
		begin
			dones++;
			assert (expect_q.size() == 0)
			else
			begin
				$display("done pulsed before all outputs of the run had appeared");
				test_errors++;
			end
		end
		if (out_valid)
		begin
			assert (filter_credits > 0)
			else
			begin
				$display("out_valid raised with no output credit at cycle %0d", cycle);
				test_errors++;
			end
			assert (expect_q.size() > 0)
			else
			begin
				$display("an output appeared after the run had ended, cycle %0d", cycle);
				test_errors++;
			end
			if (expect_q.size() > 0)
			begin
				want = expect_q.pop_front();
				assert (out_word == want)
				else
				begin
					$display("ERR out_word: expected %h, got %h (output %0d)",
						want, out_word, received);
					test_errors++;
				end
			end
			received++;
			filter_credits--;
			schedule_credit();
		end
		// inputs for the coming edge
		run_valid = start;
		coef_valid = 1'b0;
		in_valid = 1'b0;
		out_credit = 1'b0;
		if (coef_q.size() > 0 && coef_credits > 0)
		begin
			coef_valid = 1'b1;
			coef_word.coef = coef_q.pop_front();
			coef_credits--;
		end
		if (sample_q.size() > 0 && in_credits > 0)
		begin
			if (gap_left > 0)
				gap_left--;
			else
			begin
				in_valid = 1'b1;
				in_word = sample_q.pop_front();
				in_credits--;
				sent++;
				take_bits(gap_bits, gap_left);
			end
		end
		if (credit_due.size() > 0 && credit_due[0] <= cycle)
		begin
			out_credit = 1'b1;
			void'(credit_due.pop_front());
			filter_credits++;
		end
	endtask

	task automatic run_test(input int num, inout int ptr);
		int count;
		int waited;
		count = int'(vec[ptr]);
		gap_bits = int'(vec[ptr+1]);
		credit_delay = int'(vec[ptr+2]);
		ptr += 3;
		coef_q.delete();
		sample_q.delete();
		expect_q.delete();
		for (int i = 0; i < NUM_COEFS; i++)
			coef_q.push_back(coef_t'(vec[ptr+i]));
		ptr += NUM_COEFS;
		for (int i = 0; i < count; i++)
		begin
			sample_q.push_back(sample_word_t'(vec[ptr][8:0]));
			expect_q.push_back(result_t'(vec[ptr+1][8:0]));
			ptr += 2;
		end
		gap_left = 0;
		sent = 0;
		received = 0;
		dones = 0;
		credit_pulses = 0;
		test_errors = 0;
		run_cmd.count = RUN_W'(count);
		service_cycle(1'b1);
		waited = 0;
		while (dones == 0 && !timed_out)
		begin
			service_cycle(1'b0);
			waited++;
			if (waited > RUN_TIMEOUT)
			begin
				$display("timeout: test %0d saw no done within %0d cycles", num, RUN_TIMEOUT);
				timed_out = 1'b1;
			end
		end
		// credits still come back, and any stray output or done is caught here
		waited = 0;
		while (!timed_out && (credit_due.size() > 0 || waited < 4))
		begin
			service_cycle(1'b0);
			waited++;
			if (waited > DRAIN_TIMEOUT)
			begin
				$display("timeout: test %0d still owed output credits", num);
				timed_out = 1'b1;
			end
		end
		assert (received == count)
		else
		begin
			$display("ERR out_valid count: expected %h, got %h", count, received);
			test_errors++;
		end
		assert (dones == 1)
		else
		begin
			$display("ERR done pulses: expected %h, got %h", 1, dones);
			test_errors++;
		end
		assert (credit_pulses == sent)
		else
		begin
			$display("ERR in_credit pulses: expected %h, got %h", sent, credit_pulses);
			test_errors++;
		end
		$display("test %0d: run of %0d samples, %0d outputs, %0d errors",
			num, count, received, test_errors);
		errors += test_errors;
		tests_run++;
		if (test_errors != 0)
			tests_failed++;
	endtask

	initial
	begin
		int ptr;
		int num;
		clk = 1'b0;
		reset = 1'b1;
		coef_valid = 1'b0;
		coef_word = '0;
		in_valid = 1'b0;
		in_word = '0;
		run_valid = 1'b0;
		run_cmd = '0;
		out_credit = 1'b0;
		lfsr = 32'h149e;
		cycle = 0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		timed_out = 1'b0;
		$readmemh("sim/iir_vectors.txt", vec);
		repeat (10) @(posedge clk);
		#1;
		assert (!out_valid && !done && !in_credit && !coef_credit)
		else
		begin
			$display("ERR reset outputs: out_valid=%h done=%h in_credit=%h coef_credit=%h",
				out_valid, done, in_credit, coef_credit);
			errors++;
		end
		$display("test 0: reset, %0d errors", errors);
		reset = 1'b0;
		coef_credits = COEF_DEPTH;
		in_credits = IN_DEPTH;
		filter_credits = OUT_CREDITS;
		ptr = 0;
		num = 1;
		while (!timed_out && ptr < VEC_WORDS - 3 && vec[ptr] != '0)
		begin
			run_test(num, ptr);
			num++;
		end
		assert (tests_run > 0)
		else
		begin
			$display("no test vectors could be read");
			errors++;
		end
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0 && !timed_out)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

//--- sim/tb_iir_assert.sv
`timescale 1ns/1ps

module tb_iir_assert (
	input logic clk,
	input logic reset,
	input logic out_valid,
	input logic out_credit,
	input logic in_credit,
	input logic coef_credit,
	input logic done
);
	import iir_ctrl_pkg::*;

	// outputs sent that the receiver has not yet credited back
	int outstanding;

	always_ff @(posedge clk)
	begin
		if (reset)
			outstanding <= 0;
		else
			outstanding <= outstanding + int'(out_valid) - int'(out_credit);
	end

	done_single: assert property (@(posedge clk) disable iff (reset) done |=> !done)
		else $error("done lasted longer than one cycle");

	reset_quiet: assert property (@(posedge clk)
		reset |=> (!out_valid && !done && !in_credit && !coef_credit))
		else $error("outputs active right after a reset cycle");

	credit_bound: assert property (@(posedge clk) disable iff (reset)
		outstanding <= OUT_CREDITS)
		else $error("more outputs in flight than output credits");

	// a send needs a free receiver slot
	send_with_credit: assert property (@(posedge clk) disable iff (reset)
		out_valid |-> outstanding < OUT_CREDITS)
		else $error("out_valid raised with no output credit");

endmodule

bind iir_top tb_iir_assert asrt0 (
	.clk(clk),
	.reset(reset),
	.out_valid(out_valid),
	.out_credit(out_credit),
	.in_credit(in_credit),
	.coef_credit(coef_credit),
	.done(done)
);

//--- verilog/iir_credit_fifo.sv
`timescale 1ns/1ps

module iir_credit_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int DEPTH = 4
) (
	input logic clk,
	input logic reset,
	input logic wr_valid,
	input payload_t wr_data,
	output logic credit,
	input logic pop,
	output logic not_empty,
	output payload_t head
);
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic do_pop;

	// the sender never writes without a credit, so no full check
	assign do_pop = pop && not_empty;
	assign not_empty = (count != '0);
	assign head = mem[rd_ptr];

	always_ff @(posedge clk)
	begin
		if (wr_valid)
		begin
			mem[wr_ptr] <= wr_data;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credit <= 1'b0;
		end
		else
		begin
			if (wr_valid)
			begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop)
			begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({wr_valid, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			// one credit back per freed slot
			credit <= do_pop;
		end
	end

endmodule

//--- verilog/iir_ctrl_fsm.sv
`timescale 1ns/1ps

module iir_ctrl_fsm (
	input logic clk,
	input logic reset,
	input logic run_valid,
	input logic coef_ready,
	output logic coef_pop,
	output logic [iir_ctrl_pkg::COEF_IDX_W-1:0] coef_index,
	input logic sample_ready,
	output logic sample_pop,
	input logic budget_empty,
	output logic sample_done,
	output logic clear_history,
	output iir_ctrl_pkg::ctrl_state_t step,
	input logic out_credit,
	output logic out_valid
);
	import iir_ctrl_pkg::*;

	ctrl_state_t state;
	ctrl_state_t state_next;
	logic [OUT_CRED_W-1:0] credits;
	logic last_coef;

	assign step = state;
	assign clear_history = (state == IDLE) && run_valid;
	assign coef_pop = (state == LOAD_COEF) && coef_ready;
	assign last_coef = (coef_index == COEF_IDX_W'(NUM_COEFS - 1));
	// once the budget runs out no further sample is taken
	assign sample_pop = (state == WAIT_SAMPLE) && !budget_empty && sample_ready;
	assign out_valid = (state == EMIT) && (credits != '0);
	assign sample_done = out_valid;

	always_comb
	begin
		state_next = state;
		case (state)
			IDLE: if (run_valid) state_next = LOAD_COEF;
			LOAD_COEF: if (coef_pop && last_coef) state_next = WAIT_SAMPLE;
			WAIT_SAMPLE:
			begin
				if (budget_empty)
					state_next = IDLE;
				else if (sample_pop)
					state_next = MUL_FB;
			end
			MUL_FB: state_next = MUL_FF;
			MUL_FF: state_next = SUM;
			SUM: state_next = EMIT;
			// holds here while the receiver has no room
			EMIT: if (out_valid) state_next = WAIT_SAMPLE;
			default: state_next = IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= IDLE;
			coef_index <= '0;
		end
		else
		begin
			state <= state_next;
			if (clear_history)
				coef_index <= '0;
			else if (coef_pop && !last_coef)
				coef_index <= coef_index + 1'b1;
		end
	end

	// output credits, spent on out_valid and returned by the receiver
	always_ff @(posedge clk)
	begin
		if (reset)
			credits <= OUT_CRED_W'(OUT_CREDITS);
		else
		begin
			case ({out_valid, out_credit})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

endmodule

//--- verilog/iir_ctrl_pkg.sv
package iir_ctrl_pkg;

	// receive buffer depths, also the sender's initial credits
	localparam int IN_DEPTH = 4;
	localparam int COEF_DEPTH = 2;

	// receiver slots granted to the filter after reset
	localparam int OUT_CREDITS = 3;
	localparam int OUT_CRED_W = $clog2(OUT_CREDITS + 1);

	// a1, a2, b0, b1, b2
	localparam int NUM_COEFS = 5;
	localparam int COEF_IDX_W = $clog2(NUM_COEFS);

	localparam int RUN_W = 8;

	typedef enum logic [2:0] {
		IDLE,
		LOAD_COEF,
		WAIT_SAMPLE,
		MUL_FB,
		MUL_FF,
		SUM,
		EMIT
	} ctrl_state_t;

	typedef struct packed {
		logic [RUN_W-1:0] count;
	} run_cmd_t;

endpackage

//--- verilog/iir_data_pkg.sv
package iir_data_pkg;

	// sample and coefficient widths
	localparam int SAMPLE_W = 8;
	localparam int COEF_W = 16;
	localparam int ACC_W = 27;

	// product widths, products wrap here
	localparam int FB_W = 2 * COEF_W;
	localparam int FF_W = COEF_W + SAMPLE_W;

	// scaling of the feedback sum
	localparam int FB_SHIFT = 3;

	// slices of yk for the output and for the new y1
	localparam int OUT_LSB = ACC_W - SAMPLE_W;
	localparam int HIST_LSB = ACC_W - COEF_W;

	typedef logic signed [SAMPLE_W-1:0] sample_t;
	typedef logic signed [COEF_W-1:0] coef_t;

	typedef struct packed {
		coef_t coef;
	} coef_word_t;

	// last is carried through to the output untouched
	typedef struct packed {
		sample_t sample;
		logic last;
	} sample_word_t;

	typedef struct packed {
		sample_t sample;
		logic last;
	} result_t;

endpackage

//--- verilog/iir_datapath.sv
`timescale 1ns/1ps

module iir_datapath (
	input logic clk,
	input logic reset,
	input logic coef_pop,
	input logic [iir_ctrl_pkg::COEF_IDX_W-1:0] coef_index,
	input iir_data_pkg::coef_word_t coef_word,
	input logic sample_pop,
	input iir_data_pkg::sample_word_t sample_word,
	input logic clear_history,
	input iir_ctrl_pkg::ctrl_state_t step,
	output iir_data_pkg::result_t out_word
);
	import iir_data_pkg::*;
	import iir_ctrl_pkg::*;

	coef_t a1, a2, b0, b1, b2;
	coef_t y1, y2;
	sample_t u0, u1, u2;
	logic last_q;

	logic signed [FB_W-1:0] fb_sum;
	logic signed [FF_W-1:0] ff_sum;
	logic signed [ACC_W-1:0] fb_q;
	logic signed [ACC_W-1:0] ff_q;
	logic signed [ACC_W-1:0] yk;

	always_comb
	begin
		fb_sum = a1 * y1 + a2 * y2;
		ff_sum = b0 * u0 + b1 * u1 + b2 * u2;
		yk = fb_q + ff_q;
	end

	// coefficients arrive as a1, a2, b0, b1, b2
	always_ff @(posedge clk)
	begin
		if (coef_pop)
		begin
			case (coef_index)
				0: a1 <= coef_word.coef;
				1: a2 <= coef_word.coef;
				2: b0 <= coef_word.coef;
				3: b1 <= coef_word.coef;
				4: b2 <= coef_word.coef;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (sample_pop)
		begin
			u0 <= sample_word.sample;
			last_q <= sample_word.last;
		end
		case (step)
			// shift right by FB_SHIFT, only ACC_W bits survive
			MUL_FB: fb_q <= fb_sum[ACC_W+FB_SHIFT-1:FB_SHIFT];
			MUL_FF: ff_q <= {{(ACC_W - FF_W){ff_sum[FF_W-1]}}, ff_sum};
			SUM:
			begin
				out_word.sample <= yk[ACC_W-1:OUT_LSB];
				out_word.last <= last_q;
			end
			default: ;
		endcase
	end

	// history, zeroed at the start of every run
	always_ff @(posedge clk)
	begin
		if (reset || clear_history)
		begin
			y1 <= '0;
			y2 <= '0;
			u1 <= '0;
			u2 <= '0;
		end
		else if (step == SUM)
		begin
			y1 <= yk[ACC_W-1:HIST_LSB];
			y2 <= y1;
			u1 <= u0;
			u2 <= u1;
		end
	end

endmodule

//--- verilog/iir_run_budget.sv
`timescale 1ns/1ps

module iir_run_budget (
	input logic clk,
	input logic reset,
	input logic run_valid,
	input iir_ctrl_pkg::run_cmd_t run_cmd,
	input logic sample_done,
	output logic budget_empty,
	output logic done
);
	import iir_ctrl_pkg::*;

	logic [RUN_W-1:0] remaining;
	logic active;

	assign budget_empty = (remaining == '0);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			remaining <= '0;
			active <= 1'b0;
			done <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			if (!active && run_valid)
			begin
				remaining <= run_cmd.count;
				active <= (run_cmd.count != '0);
			end
			else if (active && sample_done)
			begin
				remaining <= remaining - 1'b1;
				// last sample of the run, budget_empty rises with done
				if (remaining == RUN_W'(1))
				begin
					active <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

endmodule

//--- verilog/iir_top.sv
`timescale 1ns/1ps

module iir_top (
	input logic clk,
	input logic reset,
	input logic coef_valid,
	input iir_data_pkg::coef_word_t coef_word,
	output logic coef_credit,
	input logic in_valid,
	input iir_data_pkg::sample_word_t in_word,
	output logic in_credit,
	input logic run_valid,
	input iir_ctrl_pkg::run_cmd_t run_cmd,
	output logic out_valid,
	output iir_data_pkg::result_t out_word,
	input logic out_credit,
	output logic done
);
	import iir_data_pkg::*;
	import iir_ctrl_pkg::*;

	coef_word_t coef_head;
	sample_word_t sample_head;
	logic coef_ready;
	logic coef_pop;
	logic [COEF_IDX_W-1:0] coef_index;
	logic sample_ready;
	logic sample_pop;
	logic budget_empty;
	logic sample_done;
	logic clear_history;
	ctrl_state_t step;

	iir_credit_fifo #(
		.payload_t(coef_word_t),
		.DEPTH(COEF_DEPTH)
	) coef_fifo0 (
		.clk(clk),
		.reset(reset),
		.wr_valid(coef_valid),
		.wr_data(coef_word),
		.credit(coef_credit),
		.pop(coef_pop),
		.not_empty(coef_ready),
		.head(coef_head)
	);

	iir_credit_fifo #(
		.payload_t(sample_word_t),
		.DEPTH(IN_DEPTH)
	) sample_fifo0 (
		.clk(clk),
		.reset(reset),
		.wr_valid(in_valid),
		.wr_data(in_word),
		.credit(in_credit),
		.pop(sample_pop),
		.not_empty(sample_ready),
		.head(sample_head)
	);

	iir_run_budget budget0 (
		.clk(clk),
		.reset(reset),
		.run_valid(run_valid),
		.run_cmd(run_cmd),
		.sample_done(sample_done),
		.budget_empty(budget_empty),
		.done(done)
	);

	iir_ctrl_fsm fsm0 (
		.clk(clk),
		.reset(reset),
		.run_valid(run_valid),
		.coef_ready(coef_ready),
		.coef_pop(coef_pop),
		.coef_index(coef_index),
		.sample_ready(sample_ready),
		.sample_pop(sample_pop),
		.budget_empty(budget_empty),
		.sample_done(sample_done),
		.clear_history(clear_history),
		.step(step),
		.out_credit(out_credit),
		.out_valid(out_valid)
	);

	iir_datapath datapath0 (
		.clk(clk),
		.reset(reset),
		.coef_pop(coef_pop),
		.coef_index(coef_index),
		.coef_word(coef_head),
		.sample_pop(sample_pop),
		.sample_word(sample_head),
		.clear_history(clear_history),
		.step(step),
		.out_word(out_word)
	);

endmodule
